// File: src.f
+incdir+common
common/exec_isa_pkg.sv
common/exec_ctrl_pkg.sv
common/exec_ifs.sv
hw/alu_unit.sv
hw/perf_counter.sv
hw/csr_unit.sv
lsu/lsu_ctrl.sv
lsu/lsu_unit.sv
hw/exec_top.sv
verification/exec_chk.sv
verification/exec_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module exec_tb -Mdir obj_dir -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vexec_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: verification/exec_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_tb;
    logic                     clk;
    logic                     rst_n;
    logic                     req_valid;
    logic                     req_ready;
    exec_isa_pkg::exec_unit_e req_unit;
    logic [3:0]               req_op;
    logic [4:0]               req_rd;
    logic [`XLEN-1:0]         req_rs1_data;
    logic [`XLEN-1:0]         req_rs2_data;
    logic [`XLEN-1:0]         req_imm;
    logic [`XLEN-1:0]         req_pc;
    logic                     alu_cmt_valid;
    logic                     alu_cmt_ready;
    logic [4:0]               alu_cmt_rd;
    logic                     alu_cmt_wb;
    logic [`XLEN-1:0]         alu_cmt_data;
    logic [`XLEN-1:0]         alu_cmt_pc;
    logic                     lsu_cmt_valid;
    logic                     lsu_cmt_ready;
    logic [4:0]               lsu_cmt_rd;
    logic                     lsu_cmt_wb;
    logic [`XLEN-1:0]         lsu_cmt_data;
    logic [`XLEN-1:0]         lsu_cmt_pc;
    logic                     csr_cmt_valid;
    logic                     csr_cmt_ready;
    logic [4:0]               csr_cmt_rd;
    logic                     csr_cmt_wb;
    logic [`XLEN-1:0]         csr_cmt_data;
    logic [`XLEN-1:0]         csr_cmt_pc;
    logic                     branch_valid;
    logic                     branch_taken;
    logic [`XLEN-1:0]         branch_dest;
    logic                     sim_ebreak;

    logic [31:0]      lfsr = 32'h3f9c_1a11;
    int               errors = 0;
    int               checks = 0;
    int               retired = 0;
    int               retired_at_accept;
    logic             ebreak_at_accept;
    int               c_lat;
    logic [4:0]       c_rd;
    logic             c_wb;
    logic [`XLEN-1:0] c_data;
    logic [`XLEN-1:0] c_pc;
    logic             c_bv;
    logic             c_bt;
    logic [`XLEN-1:0] c_bd;
    logic [`XLEN-1:0] mem_base = 32'h100;
    logic [`XLEN-1:0] stored [4];

    exec_top exec_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // commit handshakes before the current edge.
    always @(posedge clk) begin
        if (rst_n) begin
            retired <= retired + int'(alu_cmt_valid && alu_cmt_ready)
                     + int'(lsu_cmt_valid && lsu_cmt_ready) + int'(csr_cmt_valid && csr_cmt_ready);
        end
    end

    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // x^32+x^22+x^2+x+1.
        end
        return val;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send_req(input exec_isa_pkg::exec_unit_e unit, input logic [3:0] op,
                            input logic [4:0] rd, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] imm,
                            input logic [31:0] pc);
        int n;
        n = 0;
        req_valid    <= 1'b1;
        req_unit     <= unit;
        req_op       <= op;
        req_rd       <= rd;
        req_rs1_data <= rs1;
        req_rs2_data <= rs2;
        req_imm      <= imm;
        req_pc       <= pc;
        do begin
            @(posedge clk);
            n++;
        end while (!req_ready && n < 50);
        if (!req_ready) begin
            errors++;
            $display("timeout at %0t: request to %s was never accepted", $time, unit.name());
        end
        retired_at_accept = retired;
        ebreak_at_accept  = sim_ebreak;
        req_valid <= 1'b0;
    endtask

    task automatic wait_commit(input exec_isa_pkg::exec_unit_e port);
        logic v;
        v     = 1'b0;
        c_lat = 0;
        while (!v && c_lat < 50) begin
            @(posedge clk);
            c_lat++;
            case (port)
                exec_isa_pkg::UNIT_ALU: v = alu_cmt_valid;
                exec_isa_pkg::UNIT_LSU: v = lsu_cmt_valid;
                default:                v = csr_cmt_valid;
            endcase
        end
        if (!v) begin
            errors++;
            $display("timeout at %0t: no commit came out of %s", $time, port.name());
        end
        case (port)
            exec_isa_pkg::UNIT_ALU: {c_rd, c_wb, c_data, c_pc} =
                {alu_cmt_rd, alu_cmt_wb, alu_cmt_data, alu_cmt_pc};
            exec_isa_pkg::UNIT_LSU: {c_rd, c_wb, c_data, c_pc} =
                {lsu_cmt_rd, lsu_cmt_wb, lsu_cmt_data, lsu_cmt_pc};
            default: {c_rd, c_wb, c_data, c_pc} =
                {csr_cmt_rd, csr_cmt_wb, csr_cmt_data, csr_cmt_pc};
        endcase
        {c_bv, c_bt, c_bd} = {branch_valid, branch_taken, branch_dest};
    endtask

    task automatic test_alu_arith();
        exec_isa_pkg::alu_op_e op;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           exp;
        logic [31:0]           pc;
        logic [4:0]            rd;
        int                    e0;
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            op = exec_isa_pkg::alu_op_e'(4'(lfsr_take(3)));
            a  = lfsr_take(32);
            b  = lfsr_take(32);
            rd = 5'(lfsr_take(5));
            pc = lfsr_take(30) << 2;
            case (op)
                exec_isa_pkg::ADD: exp = a + b;
                exec_isa_pkg::SUB: exp = a - b;
                exec_isa_pkg::AND: exp = a & b;
                exec_isa_pkg::OR:  exp = a | b;
                exec_isa_pkg::XOR: exp = a ^ b;
                exec_isa_pkg::SLT: exp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                exec_isa_pkg::SLL: exp = a << b[4:0];
                default:           exp = a >> b[4:0];
            endcase
            send_req(exec_isa_pkg::UNIT_ALU, 4'(op), rd, a, b, 32'd0, pc);
            wait_commit(exec_isa_pkg::UNIT_ALU);
            compare(c_data, exp, {"alu data for ", op.name()});
            compare(32'(c_rd), 32'(rd), "alu rd");
            compare(32'(c_wb), 32'd1, "alu wb");
            compare(c_pc, pc, "alu pc");
            compare(c_lat, 32'd1, "alu commit latency");
        end
        $display("alu arithmetic finished, %0d errors", errors - e0);
    endtask

    task automatic run_branch(input exec_isa_pkg::alu_op_e op, input logic [31:0] a,
                              input logic [31:0] b, input logic exp_taken);
        logic [31:0] pc;
        logic [31:0] imm;
        pc  = lfsr_take(16) << 2;
        imm = lfsr_take(32);
        send_req(exec_isa_pkg::UNIT_ALU, 4'(op), 5'd1, a, b, imm, pc);
        wait_commit(exec_isa_pkg::UNIT_ALU);
        compare(32'(c_bv), 32'd1, {"branch_valid for ", op.name()});
        compare(32'(c_bt), 32'(exp_taken), {"branch_taken for ", op.name()});
        compare(c_bd, pc + imm, {"branch_dest for ", op.name()});
        if (op == exec_isa_pkg::JAL) begin
            compare(32'(c_wb), 32'd1, "jal wb");
            compare(c_data, pc + 32'd4, "jal link value");
        end else begin
            compare(32'(c_wb), 32'd0, {"branch wb for ", op.name()});
        end
    endtask

    task automatic run_helper(input exec_isa_pkg::alu_op_e op);
        send_req(exec_isa_pkg::UNIT_ALU, 4'(op), 5'd0, 32'd0, 32'd0, 32'd0, 32'h80);
        compare(32'(ebreak_at_accept), 32'd1, {"sim_ebreak for ", op.name()});
        wait_commit(exec_isa_pkg::UNIT_ALU);
        compare(32'(c_wb), 32'd0, {"wb for ", op.name()});
        compare(32'(c_bv), 32'd0, {"branch_valid for ", op.name()});
    endtask

    task automatic test_branches();
        logic [31:0] x;
        int          e0;
        e0 = errors;
        x  = lfsr_take(32);
        run_branch(exec_isa_pkg::BEQ, x, x, 1'b1);
        run_branch(exec_isa_pkg::BEQ, x, x ^ 32'd1, 1'b0);
        run_branch(exec_isa_pkg::BNE, x, x ^ 32'd1, 1'b1);
        run_branch(exec_isa_pkg::BNE, x, x, 1'b0);
        run_branch(exec_isa_pkg::BLT, 32'hffff_fffb, 32'd3, 1'b1);  // -5 < 3.
        run_branch(exec_isa_pkg::BLT, 32'd3, 32'hffff_fffb, 1'b0);
        run_branch(exec_isa_pkg::JAL, lfsr_take(32), 32'd0, 1'b1);
        run_helper(exec_isa_pkg::EBREAK);
        run_helper(exec_isa_pkg::ECALL);
        $display("branches and helpers finished, %0d errors", errors - e0);
    endtask

    task automatic test_memory();
        int e0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            stored[i] = lfsr_take(32);
            send_req(exec_isa_pkg::UNIT_LSU, 4'(exec_isa_pkg::SW), 5'd0, mem_base, stored[i],
                     32'(i * 8), 32'h200 + 32'(i * 4));
            wait_commit(exec_isa_pkg::UNIT_LSU);
            compare(32'(c_wb), 32'd0, "store wb");
            compare(c_pc, 32'h200 + 32'(i * 4), "store pc");
            // valid rises after edge N+L+1 and is first sampled one edge later.
            compare(c_lat, `MEM_LATENCY + 2, "store commit latency");
        end
        for (int i = 0; i < 4; i++) begin
            send_req(exec_isa_pkg::UNIT_LSU, 4'(exec_isa_pkg::LW), 5'(i + 8),
                     mem_base + 32'(i * 8) - 32'd4, 32'd0, 32'd4, 32'h300);
            wait_commit(exec_isa_pkg::UNIT_LSU);
            compare(c_data, stored[i], "load data");
            compare(32'(c_wb), 32'd1, "load wb");
            compare(32'(c_rd), 32'(i + 8), "load rd");
            compare(c_lat, `MEM_LATENCY + 2, "load commit latency");
        end
        $display("memory finished, %0d errors", errors - e0);
    endtask

    task automatic test_backpressure();
        logic [31:0] held_data;
        logic [31:0] held_pc;
        logic [31:0] a;
        logic [31:0] b;
        int          e0;
        e0 = errors;
        lsu_cmt_ready <= 1'b0;
        send_req(exec_isa_pkg::UNIT_LSU, 4'(exec_isa_pkg::LW), 5'd7, mem_base, 32'd0,
                 32'd16, 32'h400);
        wait_commit(exec_isa_pkg::UNIT_LSU);
        held_data = c_data;
        held_pc   = c_pc;
        for (int i = 0; i < 3; i++) begin
            a = lfsr_take(32);
            b = lfsr_take(32);
            send_req(exec_isa_pkg::UNIT_ALU, 4'(exec_isa_pkg::ADD), 5'd2, a, b, 32'd0, 32'h40);
            wait_commit(exec_isa_pkg::UNIT_ALU);
            compare(c_data, a + b, "alu data while lsu is held");
        end
        req_unit <= exec_isa_pkg::UNIT_LSU;
        for (int n = 0; n < 10; n++) begin
            @(posedge clk);
            compare(32'(lsu_cmt_valid), 32'd1, "held lsu valid");
            compare(lsu_cmt_data, held_data, "held lsu data");
            compare(lsu_cmt_pc, held_pc, "held lsu pc");
            compare(32'(req_ready), 32'd0, "lsu req_ready while held");
        end
        lsu_cmt_ready <= 1'b1;
        @(posedge clk);
        compare(32'(lsu_cmt_valid), 32'd1, "lsu valid at release");
        compare(lsu_cmt_data, stored[2], "lsu data at release");
        @(posedge clk);
        compare(32'(lsu_cmt_valid), 32'd0, "lsu valid after release");
        // alu commit held by its own ready.
        alu_cmt_ready <= 1'b0;
        a = lfsr_take(32);
        b = lfsr_take(32);
        send_req(exec_isa_pkg::UNIT_ALU, 4'(exec_isa_pkg::XOR), 5'd4, a, b, 32'd0, 32'h44);
        for (int n = 0; n < 4; n++) begin
            wait_commit(exec_isa_pkg::UNIT_ALU);
            compare(c_lat, 32'd1, "held alu valid");
            compare(c_data, a ^ b, "held alu data");
            compare(c_pc, 32'h44, "held alu pc");
        end
        alu_cmt_ready <= 1'b1;
        $display("back-pressure finished, %0d errors", errors - e0);
    endtask

    task automatic csr_access(input exec_isa_pkg::csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] value);
        send_req(exec_isa_pkg::UNIT_CSR, 4'(op), 5'd3, value, 32'd0, 32'(addr), 32'h500);
        wait_commit(exec_isa_pkg::UNIT_CSR);
        compare(32'(c_wb), 32'd1, "csr wb");
        compare(32'(c_rd), 32'd3, "csr rd");
        compare(c_pc, 32'h500, "csr pc");
    endtask

    task automatic test_csr();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] first;
        int          e0;
        e0 = errors;
        v1 = lfsr_take(32);
        v2 = lfsr_take(32);
        csr_access(exec_isa_pkg::CSRRW, `CSR_SCRATCH, v1);
        compare(c_data, 32'd0, "scratch after reset");
        csr_access(exec_isa_pkg::CSRRS, `CSR_SCRATCH, v2);
        compare(c_data, v1, "scratch old value on set");
        csr_cmt_ready <= 1'b0;
        csr_access(exec_isa_pkg::CSRR, `CSR_SCRATCH, 32'd0);
        compare(c_data, v1 | v2, "scratch new value");
        wait_commit(exec_isa_pkg::UNIT_CSR);
        compare(c_lat, 32'd1, "held csr valid");
        compare(c_data, v1 | v2, "held csr data");
        csr_cmt_ready <= 1'b1;
        csr_access(exec_isa_pkg::CSRR, `CSR_INSTRET, 32'd0);
        compare(c_data, retired_at_accept, "instret");
        csr_access(exec_isa_pkg::CSRR, `CSR_CYCLE, 32'd0);
        first = c_data;
        csr_access(exec_isa_pkg::CSRR, `CSR_CYCLE, 32'd0);
        compare(32'(c_data > first), 32'd1, "cycle increasing");
        $display("csr finished, %0d errors", errors - e0);
    endtask

    initial begin
        rst_n         <= 1'b0;
        req_valid     <= 1'b0;
        req_unit      <= exec_isa_pkg::UNIT_ALU;
        req_op        <= '0;
        req_rd        <= '0;
        req_rs1_data  <= '0;
        req_rs2_data  <= '0;
        req_imm       <= '0;
        req_pc        <= '0;
        alu_cmt_ready <= 1'b1;
        lsu_cmt_ready <= 1'b1;
        csr_cmt_ready <= 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_alu_arith();
        test_branches();
        test_memory();
        test_backpressure();
        test_csr();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

// File: verification/exec_chk.sv
`timescale 1ns/1ps

module exec_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req_valid,
    input logic                     req_ready,
    input exec_isa_pkg::exec_unit_e req_unit,
    input logic                     sim_ebreak,
    input logic                     alu_cmt_valid,
    input logic                     alu_cmt_ready,
    input logic                     alu_cmt_wb,
    input logic                     lsu_cmt_valid,
    input logic                     lsu_cmt_ready,
    input logic                     csr_cmt_valid,
    input logic                     csr_cmt_ready
);
    alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        alu_cmt_valid && !alu_cmt_ready |=> alu_cmt_valid)
        else $error("alu commit valid dropped before its handshake");

    lsu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_cmt_valid && !lsu_cmt_ready |=> lsu_cmt_valid)
        else $error("lsu commit valid dropped before its handshake");

    csr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        csr_cmt_valid && !csr_cmt_ready |=> csr_cmt_valid)
        else $error("csr commit valid dropped before its handshake");

    ebreak_in_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        sim_ebreak |-> req_valid && req_ready && req_unit == exec_isa_pkg::UNIT_ALU)
        else $error("sim_ebreak outside an alu handshake");

    // helper ops commit on the next edge with no write-back.
    ebreak_commit: assert property (@(posedge clk) disable iff (!rst_n)
        sim_ebreak |=> alu_cmt_valid && !alu_cmt_wb)
        else $error("ebreak or ecall did not commit with wb low");

    // reset edge clears them, so they read low one edge later.
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !(alu_cmt_valid || lsu_cmt_valid || csr_cmt_valid))
        else $error("commit valid during reset");
endmodule

bind exec_top exec_chk chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_unit      (req_unit),
    .sim_ebreak    (sim_ebreak),
    .alu_cmt_valid (alu_cmt_valid),
    .alu_cmt_ready (alu_cmt_ready),
    .alu_cmt_wb    (alu_cmt_wb),
    .lsu_cmt_valid (lsu_cmt_valid),
    .lsu_cmt_ready (lsu_cmt_ready),
    .csr_cmt_valid (csr_cmt_valid),
    .csr_cmt_ready (csr_cmt_ready)
);

// File: hw/exec_top.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  exec_isa_pkg::exec_unit_e req_unit,
    input  logic [3:0]               req_op,
    input  logic [4:0]               req_rd,
    input  logic [`XLEN-1:0]         req_rs1_data,
    input  logic [`XLEN-1:0]         req_rs2_data,
    input  logic [`XLEN-1:0]         req_imm,
    input  logic [`XLEN-1:0]         req_pc,
    output logic                     alu_cmt_valid,
    input  logic                     alu_cmt_ready,
    output logic [4:0]               alu_cmt_rd,
    output logic                     alu_cmt_wb,
    output logic [`XLEN-1:0]         alu_cmt_data,
    output logic [`XLEN-1:0]         alu_cmt_pc,
    output logic                     lsu_cmt_valid,
    input  logic                     lsu_cmt_ready,
    output logic [4:0]               lsu_cmt_rd,
    output logic                     lsu_cmt_wb,
    output logic [`XLEN-1:0]         lsu_cmt_data,
    output logic [`XLEN-1:0]         lsu_cmt_pc,
    output logic                     csr_cmt_valid,
    input  logic                     csr_cmt_ready,
    output logic [4:0]               csr_cmt_rd,
    output logic                     csr_cmt_wb,
    output logic [`XLEN-1:0]         csr_cmt_data,
    output logic [`XLEN-1:0]         csr_cmt_pc,
    output logic                     branch_valid,
    output logic                     branch_taken,
    output logic [`XLEN-1:0]         branch_dest,
    output logic                     sim_ebreak
);
    logic       running;
    logic [2:0] unit_ready;
    logic [2:0] cmt_fire;
    logic [1:0] retire_cnt;

    exec_req_if unit_req[3] ();
    commit_if   alu_cmt ();
    commit_if   lsu_cmt ();
    commit_if   csr_cmt ();

    // no unit takes a request before the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_req
        assign unit_req[i].valid    = running && req_valid
                                   && (req_unit == exec_isa_pkg::exec_unit_e'(i));  // unit encoding.
        assign unit_req[i].op       = req_op;
        assign unit_req[i].rd       = req_rd;
        assign unit_req[i].rs1_data = req_rs1_data;
        assign unit_req[i].rs2_data = req_rs2_data;
        assign unit_req[i].imm      = req_imm;
        assign unit_req[i].pc       = req_pc;
        assign unit_ready[i]        = unit_req[i].ready;
    end

    always_comb begin
        case (req_unit)
            exec_isa_pkg::UNIT_ALU: req_ready = running && unit_ready[0];
            exec_isa_pkg::UNIT_LSU: req_ready = running && unit_ready[1];
            exec_isa_pkg::UNIT_CSR: req_ready = running && unit_ready[2];
            default:                req_ready = 1'b0;
        endcase
    end

    alu_unit alu_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (unit_req[0]),
        .cmt          (alu_cmt),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest)
    );

    lsu_unit lsu_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (unit_req[1]),
        .cmt   (lsu_cmt)
    );

    csr_unit csr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (unit_req[2]),
        .cmt        (csr_cmt),
        .retire_cnt (retire_cnt)
    );

    assign alu_cmt_valid = alu_cmt.valid;
    assign alu_cmt.ready = alu_cmt_ready;
    assign alu_cmt_rd    = alu_cmt.rd;
    assign alu_cmt_wb    = alu_cmt.wb;
    assign alu_cmt_data  = alu_cmt.data;
    assign alu_cmt_pc    = alu_cmt.pc;

    assign lsu_cmt_valid = lsu_cmt.valid;
    assign lsu_cmt.ready = lsu_cmt_ready;
    assign lsu_cmt_rd    = lsu_cmt.rd;
    assign lsu_cmt_wb    = lsu_cmt.wb;
    assign lsu_cmt_data  = lsu_cmt.data;
    assign lsu_cmt_pc    = lsu_cmt.pc;

    assign csr_cmt_valid = csr_cmt.valid;
    assign csr_cmt.ready = csr_cmt_ready;
    assign csr_cmt_rd    = csr_cmt.rd;
    assign csr_cmt_wb    = csr_cmt.wb;
    assign csr_cmt_data  = csr_cmt.data;
    assign csr_cmt_pc    = csr_cmt.pc;

    // retired instructions this cycle, up to three.
    assign cmt_fire   = {csr_cmt.valid && csr_cmt.ready,
                         lsu_cmt.valid && lsu_cmt.ready,
                         alu_cmt.valid && alu_cmt.ready};
    assign retire_cnt = 2'(cmt_fire[0]) + 2'(cmt_fire[1]) + 2'(cmt_fire[2]);

    assign sim_ebreak = unit_req[0].valid && unit_ready[0]
                     && (exec_isa_pkg::alu_op_e'(req_op) == exec_isa_pkg::EBREAK
                      || exec_isa_pkg::alu_op_e'(req_op) == exec_isa_pkg::ECALL);
endmodule

// File: lsu/lsu_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module lsu_unit (
    input  logic      clk,
    input  logic      rst_n,
    exec_req_if.slave req,
    commit_if.master  cmt
);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    exec_isa_pkg::lsu_op_e op_q;
    logic [`XLEN-1:0]      addr;
    logic [IDX_W-1:0]      idx_q;
    logic [`XLEN-1:0]      sdata_q;
    logic [`XLEN-1:0]      mem [`MEM_WORDS];
    logic                  fire;
    logic                  mem_we_en;

    assign fire = req.valid && req.ready;
    assign addr = req.rs1_data + req.imm;

    lsu_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_fire  (fire),
        .cmt_ready (cmt.ready),
        .req_ready (req.ready),
        .mem_we_en (mem_we_en),
        .cmt_valid (cmt.valid)
    );

    always_ff @(posedge clk) begin
        if (fire) begin
            op_q    <= exec_isa_pkg::lsu_op_e'(req.op[0]);
            idx_q   <= addr[IDX_W+1:2];  // word index.
            sdata_q <= req.rs2_data;
            cmt.rd  <= req.rd;
            cmt.pc  <= req.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we_en && op_q == exec_isa_pkg::SW) begin
            mem[idx_q] <= sdata_q;
        end
    end

    assign cmt.wb   = (op_q == exec_isa_pkg::LW);
    assign cmt.data = mem[idx_q];  // stable while the commit is held.
endmodule

// File: lsu/lsu_ctrl.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module lsu_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic req_fire,
    input  logic cmt_ready,
    output logic req_ready,
    output logic mem_we_en,
    output logic cmt_valid
);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    exec_ctrl_pkg::lsu_state_e state;
    exec_ctrl_pkg::lsu_state_e state_next;
    logic [CNT_W-1:0]          wait_cnt;

    always_comb begin
        state_next = state;
        case (state)
            exec_ctrl_pkg::S_IDLE: begin
                if (req_fire) begin
                    state_next = exec_ctrl_pkg::S_WAIT;
                end
            end
            exec_ctrl_pkg::S_WAIT: begin
                if (wait_cnt == '0) begin
                    state_next = exec_ctrl_pkg::S_COMMIT;
                end
            end
            exec_ctrl_pkg::S_COMMIT: begin
                if (cmt_ready) begin
                    state_next = exec_ctrl_pkg::S_IDLE;
                end
            end
            default: state_next = exec_ctrl_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= exec_ctrl_pkg::S_IDLE;
            wait_cnt <= '0;
        end else begin
            state <= state_next;
            if (req_fire) begin
                wait_cnt <= CNT_W'(`MEM_LATENCY);
            end else if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    assign req_ready = (state == exec_ctrl_pkg::S_IDLE);
    assign cmt_valid = (state == exec_ctrl_pkg::S_COMMIT);
    assign mem_we_en = (state == exec_ctrl_pkg::S_WAIT) && (wait_cnt == '0);  // entering commit.
endmodule

// File: hw/csr_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module csr_unit (
    input  logic       clk,
    input  logic       rst_n,
    exec_req_if.slave  req,
    commit_if.master   cmt,
    input  logic [1:0] retire_cnt
);
    exec_isa_pkg::csr_op_e op;
    logic [11:0]           addr;
    logic [`XLEN-1:0]      scratch;
    logic [`XLEN-1:0]      cycle_lo;
    logic [`XLEN-1:0]      cycle_hi;
    logic [`XLEN-1:0]      instret_lo;
    logic [`XLEN-1:0]      instret_hi;
    logic [`XLEN-1:0]      rdata;
    logic                  fire;

    assign op        = exec_isa_pkg::csr_op_e'(req.op[1:0]);
    assign addr      = req.imm[11:0];
    assign req.ready = !cmt.valid || cmt.ready;
    assign fire      = req.valid && req.ready;
    assign cmt.wb    = 1'b1;

    perf_counter cycle_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (2'd1),
        .rd_hi (addr == `CSR_CYCLEH),
        .lo    (cycle_lo),
        .hi    (cycle_hi)
    );

    perf_counter instret_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .inc   (retire_cnt),
        .rd_hi (addr == `CSR_INSTRETH),
        .lo    (instret_lo),
        .hi    (instret_hi)
    );

    always_comb begin
        case (addr)
            `CSR_SCRATCH:  rdata = scratch;
            `CSR_CYCLE:    rdata = cycle_lo;
            `CSR_CYCLEH:   rdata = cycle_hi;
            `CSR_INSTRET:  rdata = instret_lo;
            `CSR_INSTRETH: rdata = instret_hi;
            default:       rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch   <= '0;
            cmt.valid <= 1'b0;
        end else begin
            if (fire && addr == `CSR_SCRATCH) begin
                if (op == exec_isa_pkg::CSRRW) begin
                    scratch <= req.rs1_data;
                end else if (op == exec_isa_pkg::CSRRS) begin
                    scratch <= scratch | req.rs1_data;
                end
            end
            if (fire) begin
                cmt.valid <= 1'b1;
            end else if (cmt.ready) begin
                cmt.valid <= 1'b0;
            end
        end
    end

    // old value goes back to rd.
    always_ff @(posedge clk) begin
        if (fire) begin
            cmt.rd   <= req.rd;
            cmt.data <= rdata;
            cmt.pc   <= req.pc;
        end
    end
endmodule

// File: hw/perf_counter.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module perf_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [1:0]       inc,
    input  logic             rd_hi,
    output logic [`XLEN-1:0] lo,
    output logic [`XLEN-1:0] hi
);
    logic [2*`XLEN-1:0] count;
    logic [`XLEN-1:0]   hi_snap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            hi_snap <= '0;
        end else begin
            count <= count + {{(2*`XLEN-2){1'b0}}, inc};
            if (!rd_hi) begin
                hi_snap <= count[2*`XLEN-1:`XLEN];  // frozen while high half is read.
            end
        end
    end

    assign lo = count[`XLEN-1:0];
    assign hi = rd_hi ? hi_snap : count[2*`XLEN-1:`XLEN];
endmodule

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu_unit (
    input  logic             clk,
    input  logic             rst_n,
    exec_req_if.slave        req,
    commit_if.master         cmt,
    output logic             branch_valid,
    output logic             branch_taken,
    output logic [`XLEN-1:0] branch_dest
);
    exec_isa_pkg::alu_op_e op;
    logic [`XLEN-1:0]      result;
    logic                  wb;
    logic                  is_br;
    logic                  taken;
    logic                  fire;

    assign op        = exec_isa_pkg::alu_op_e'(req.op);
    assign req.ready = !cmt.valid || cmt.ready;
    assign fire      = req.valid && req.ready;

    always_comb begin
        result = '0;
        wb     = 1'b1;
        is_br  = 1'b0;
        taken  = 1'b0;
        case (op)
            exec_isa_pkg::ADD: result = req.rs1_data + req.rs2_data;
            exec_isa_pkg::SUB: result = req.rs1_data - req.rs2_data;
            exec_isa_pkg::AND: result = req.rs1_data & req.rs2_data;
            exec_isa_pkg::OR:  result = req.rs1_data | req.rs2_data;
            exec_isa_pkg::XOR: result = req.rs1_data ^ req.rs2_data;
            exec_isa_pkg::SLT: result = `XLEN'($signed(req.rs1_data) < $signed(req.rs2_data));
            exec_isa_pkg::SLL: result = req.rs1_data << req.rs2_data[$clog2(`XLEN)-1:0];
            exec_isa_pkg::SRL: result = req.rs1_data >> req.rs2_data[$clog2(`XLEN)-1:0];
            exec_isa_pkg::BEQ: begin
                is_br = 1'b1;
                taken = (req.rs1_data == req.rs2_data);
                wb    = 1'b0;
            end
            exec_isa_pkg::BNE: begin
                is_br = 1'b1;
                taken = (req.rs1_data != req.rs2_data);
                wb    = 1'b0;
            end
            exec_isa_pkg::BLT: begin
                is_br = 1'b1;
                taken = ($signed(req.rs1_data) < $signed(req.rs2_data));
                wb    = 1'b0;
            end
            exec_isa_pkg::JAL: begin
                is_br  = 1'b1;
                taken  = 1'b1;
                result = req.pc + `XLEN'(4);  // link address.
            end
            default: wb = 1'b0;  // ebreak, ecall.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmt.valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            if (fire) begin
                cmt.valid <= 1'b1;
            end else if (cmt.ready) begin
                cmt.valid <= 1'b0;
            end
            branch_valid <= fire && is_br;  // one cycle, with the commit.
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            cmt.rd       <= req.rd;
            cmt.wb       <= wb;
            cmt.data     <= result;
            cmt.pc       <= req.pc;
            branch_taken <= taken;
            branch_dest  <= req.pc + req.imm;
        end
    end
endmodule

// File: common/exec_ifs.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

interface exec_req_if;
    logic             valid;
    logic             ready;
    logic [3:0]       op;  // meaning depends on the unit.
    logic [4:0]       rd;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] pc;

    modport master (
        output valid, op, rd, rs1_data, rs2_data, imm, pc,
        input  ready
    );

    modport slave (
        input  valid, op, rd, rs1_data, rs2_data, imm, pc,
        output ready
    );
endinterface

interface commit_if;
    logic             valid;
    logic             ready;
    logic [4:0]       rd;
    logic             wb;  // register write-back.
    logic [`XLEN-1:0] data;
    logic [`XLEN-1:0] pc;

    modport master (output valid, rd, wb, data, pc, input ready);
    modport slave  (input valid, rd, wb, data, pc, output ready);
endinterface

// File: common/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

    // lsu access controller.
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_COMMIT
    } lsu_state_e;

endpackage

// File: common/exec_isa_pkg.sv
package exec_isa_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_LSU,
        UNIT_CSR
    } exec_unit_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLL, SRL,
        BEQ, BNE, BLT, JAL,
        EBREAK, ECALL  // simulation helpers.
    } alu_op_e;

    typedef enum logic [0:0] {
        LW,
        SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        CSRR,
        CSRRW,
        CSRRS
    } csr_op_e;

endpackage

// File: common/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

`define XLEN            32

// data memory, word addressed through addr[9:2].
`define MEM_WORDS       256
`define MEM_LATENCY     3

// csr addresses, carried in imm[11:0].
`define CSR_SCRATCH     12'h340
`define CSR_CYCLE       12'hC00
`define CSR_CYCLEH      12'hC80
`define CSR_INSTRET     12'hC02
`define CSR_INSTRETH    12'hC82

`endif
